//--- design/pfu_pkg.sv
/*
 * pre-fetch package
 * shared widths, start-of-fetch code and FIFO entry types
 */

`default_nettype none

package pfu_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int xlen   = 32;
    localparam int atom_w = 16;

    // start-of-fetch id seen by the decoder
    typedef enum logic [0:0] {
        sofid_run  = 1'b0,
        sofid_jump = 1'b1
    } sofid_e;

    // privilege tag carried on the request only
    typedef logic [1:0] hpl_t;

    // ----------------------------------------------------------------------
    // fifo entries
    // ----------------------------------------------------------------------
    // word address of a fetched line plus its bus error
    typedef struct packed {
        logic        ferr;
        logic [29:0] addr;
    } line_entry_t;

    // one halfword and its first-atom-after-redirect mark
    typedef struct packed {
        logic              sof;
        logic [atom_w-1:0] atom;
    } atom_entry_t;

endpackage

`default_nettype wire

//--- design/ibus_if.sv
/*
 * instruction bus
 * request and response channels between pre-fetch unit and SRAM
 */

`timescale 1ns/1ps
`default_nettype none

interface ibus_if;
    import pfu_pkg::*;

    // request channel
    logic            req_valid;
    logic            req_ready;
    hpl_t            req_hpl;
    logic [xlen-1:0] req_addr;
    // response channel
    logic            rsp_valid;
    logic            rsp_ready;
    logic            rsp_rerr;
    logic [xlen-1:0] rsp_data;

    // fetch side
    modport master (
        output req_valid, req_hpl, req_addr, rsp_ready,
        input  req_ready, rsp_valid, rsp_rerr, rsp_data
    );

    // memory side
    modport slave (
        input  req_valid, req_hpl, req_addr, rsp_ready,
        output req_ready, rsp_valid, rsp_rerr, rsp_data
    );
endinterface

`default_nettype wire

//--- design/pfu_fifo.sv
/*
 * pre-fetch FIFO
 * circular buffer with flush and optional pass-through when empty
 */

`timescale 1ns/1ps
`default_nettype none

module pfu_fifo #(
    parameter int  FIFO_DEPTH_X     = 2,
    parameter bit  FIFO_PASSTHROUGH = 1'b0,
    parameter type payload_t        = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     wr_i,
    input  payload_t din_i,
    input  logic     rd_i,
    output logic     empty_o,
    output logic     full_o,
    output payload_t dout_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_X;

    // storage
    payload_t              mem_q [DEPTH];
    // pointers carry one wrap bit above the index
    logic [FIFO_DEPTH_X:0] wr_ptr_q;
    logic [FIFO_DEPTH_X:0] rd_ptr_q;
    logic                  ptr_empty;
    logic                  bypass;
    logic                  push;
    logic                  pop;

    assign ptr_empty = (wr_ptr_q == rd_ptr_q);
    // full when only the wrap bits differ
    assign full_o    = ((wr_ptr_q ^ rd_ptr_q) == {1'b1, {FIFO_DEPTH_X{1'b0}}});

    // empty buffer forwards the write straight to the head
    assign bypass  = FIFO_PASSTHROUGH && ptr_empty && wr_i;
    assign empty_o = ptr_empty & ~bypass;
    assign dout_o  = bypass ? din_i : mem_q[rd_ptr_q[FIFO_DEPTH_X-1:0]];

    // forwarded entry read in the same cycle is never stored
    assign push = wr_i & ~full_o & ~(bypass & rd_i);
    assign pop  = rd_i & ~ptr_empty;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q[FIFO_DEPTH_X-1:0]] <= din_i;
        end
    end

endmodule

`default_nettype wire

//--- design/pfu_fetch.sv
/*
 * pre-fetch unit
 * fetches aligned words, splits them into halfword atoms and
 * presents one 16 or 32 bit instruction at a time to the decoder
 */

`timescale 1ns/1ps
`default_nettype none

module pfu_fetch #(
    parameter int                         FIFO_DEPTH_X     = 2,
    parameter bit                         FIFO_PASSTHROUGH = 1'b0,
    parameter logic [pfu_pkg::xlen-1:0]   RESET_VECTOR     = '0
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    ibus_if.master                        bus,
    input  pfu_pkg::hpl_t                 exs_hpl_i,
    input  logic                          exs_pc_wr_i,
    input  logic [pfu_pkg::xlen-1:0]      exs_pc_din_i,
    output logic                          ids_dav_o,
    input  logic                          ids_ack_i,
    input  logic [1:0]                    ids_ack_size_i,
    output pfu_pkg::sofid_e               ids_sofid_o,
    output logic [pfu_pkg::xlen-1:0]      ids_ins_o,
    output logic                          ids_ferr_o,
    output logic [pfu_pkg::xlen-1:0]      ids_pc_o
);
    import pfu_pkg::*;

    localparam logic [FIFO_DEPTH_X:0] LEVEL_INIT = 1 << FIFO_DEPTH_X;

    // bus bookkeeping
    logic                  request_gate_q;
    logic                  ibus_debt_q;
    logic                  request;
    logic                  response;
    // free entries left for new requests
    logic [FIFO_DEPTH_X:0] fifo_level_q;
    logic                  fifo_accepting;
    logic [xlen-1:0]       pc_q;
    logic [xlen-1:0]       request_addr_q;
    // redirect tracking
    logic                  vectoring_q;
    logic                  sofid_q;
    logic                  flush;
    // line fifo
    line_entry_t           line_din;
    line_entry_t           line_dout;
    logic                  line_rd;
    logic                  line_empty;
    // atom fifos with index 0 holding the low halfword of a word
    atom_entry_t           atom_din  [2];
    atom_entry_t           atom_dout [2];
    logic [1:0]            atom_empty;
    logic [1:0]            atom_wr_mask;
    logic [1:0]            atom_rd_mask;
    logic [1:0]            atom_sof_din;
    logic [1:0]            atom_sof;
    // which atom fifo holds the current low halfword
    logic                  atom_base_q;
    logic                  atom_base;

    // ----------------------------------------------------------------------
    // bus request side
    // ----------------------------------------------------------------------
    // no new request in a redirect cycle or with an unanswered one pending
    assign bus.req_valid = request_gate_q & fifo_accepting & ~exs_pc_wr_i
                         & (~ibus_debt_q | response);
    assign bus.req_hpl   = exs_hpl_i;
    assign bus.req_addr  = {pc_q[xlen-1:2], 2'b00};
    // credit reserves room for every response
    assign bus.rsp_ready = 1'b1;

    assign request  = bus.req_valid & bus.req_ready;
    assign response = bus.rsp_valid & bus.rsp_ready;
    assign flush    = exs_pc_wr_i | vectoring_q;

    // held off for the first cycle out of reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            request_gate_q <= 1'b0;
        end else begin
            request_gate_q <= 1'b1;
        end
    end

    // single outstanding request
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ibus_debt_q <= 1'b0;
        end else if (request & ~response) begin
            ibus_debt_q <= 1'b1;
        end else if (~request & response) begin
            ibus_debt_q <= 1'b0;
        end
    end

    // credit refilled on redirect since the fifos are flushed
    always_ff @(posedge clk_i) begin
        if (reset_i || exs_pc_wr_i) begin
            fifo_level_q <= LEVEL_INIT;
        end else if (request & ~line_rd) begin
            fifo_level_q <= fifo_level_q - 1'b1;
        end else if (~request & line_rd) begin
            fifo_level_q <= fifo_level_q + 1'b1;
        end
    end
    assign fifo_accepting = |fifo_level_q;

    // ----------------------------------------------------------------------
    // program counter and redirect
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_VECTOR;
        end else if (exs_pc_wr_i) begin
            pc_q <= exs_pc_din_i;
        end else if (request) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // address of the request in flight with its halfword bit
    always_ff @(posedge clk_i) begin
        if (request) begin
            request_addr_q <= pc_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vectoring_q <= 1'b0;
        end else if (exs_pc_wr_i) begin
            vectoring_q <= 1'b1;
        end else if (request) begin
            vectoring_q <= 1'b0;
        end
    end

    // first response after a redirect carries start-of-fetch
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sofid_q <= 1'b0;
        end else if (vectoring_q & request) begin
            sofid_q <= 1'b1;
        end else if (response) begin
            sofid_q <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // line and atom fifos
    // ----------------------------------------------------------------------
    // line retires once its high atom is consumed
    assign line_rd       = ids_ack_i & (atom_base | ids_ack_size_i[1]);
    assign line_din.ferr = bus.rsp_rerr;
    assign line_din.addr = request_addr_q[xlen-1:2];

    pfu_fifo #(
        .FIFO_DEPTH_X     (FIFO_DEPTH_X),
        .FIFO_PASSTHROUGH (FIFO_PASSTHROUGH),
        .payload_t        (line_entry_t)
    ) u_line_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush),
        .wr_i    (response),
        .din_i   (line_din),
        .rd_i    (line_rd),
        .empty_o (line_empty),
        .full_o  (),
        .dout_o  (line_dout)
    );

    // odd redirect target skips the low atom
    assign atom_wr_mask = {1'b1, ~(sofid_q & request_addr_q[1])};
    assign atom_sof_din = {sofid_q & request_addr_q[1], sofid_q & ~request_addr_q[1]};
    assign atom_rd_mask = {atom_base | ids_ack_size_i[1], ~atom_base | ids_ack_size_i[1]};

    for (genvar g = 0; g < 2; g++) begin : g_atom
        assign atom_din[g].sof  = atom_sof_din[g];
        assign atom_din[g].atom = bus.rsp_data[atom_w*g +: atom_w];
        assign atom_sof[g]      = atom_dout[g].sof;

        pfu_fifo #(
            .FIFO_DEPTH_X     (FIFO_DEPTH_X),
            .FIFO_PASSTHROUGH (FIFO_PASSTHROUGH),
            .payload_t        (atom_entry_t)
        ) u_atom_fifo (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .flush_i (flush),
            .wr_i    (response & atom_wr_mask[g]),
            .din_i   (atom_din[g]),
            .rd_i    (ids_ack_i & atom_rd_mask[g]),
            .empty_o (atom_empty[g]),
            .full_o  (),
            .dout_o  (atom_dout[g])
        );
    end

    // ----------------------------------------------------------------------
    // atom base pointer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            atom_base_q <= 1'b0;
        end else if (ids_ack_i) begin
            if (|atom_sof) begin
                // base restarts from the sof atom
                atom_base_q <= ids_ack_size_i[1] ? atom_sof[1] : ~atom_sof[1];
            end else if (~ids_ack_size_i[1]) begin
                atom_base_q <= ~atom_base_q;
            end
        end
    end

    // sof atom overrides the stored base
    assign atom_base = (|atom_sof) ? atom_sof[1] : atom_base_q;

    // ----------------------------------------------------------------------
    // decoder outputs
    // ----------------------------------------------------------------------
    assign ids_dav_o  = ~line_empty & ~(|atom_empty);
    assign ids_ferr_o = line_dout.ferr;
    assign ids_pc_o   = {line_dout.addr, atom_base, 1'b0};

    always_comb begin
        if (atom_base) begin
            ids_ins_o = {atom_dout[0].atom, atom_dout[1].atom};
        end else begin
            ids_ins_o = {atom_dout[1].atom, atom_dout[0].atom};
        end
        ids_sofid_o = (|atom_sof) ? sofid_jump : sofid_run;
    end

endmodule

`default_nettype wire

//--- design/imem_sram.sv
/*
 * instruction SRAM
 * answers one cycle after a request, flags reads past its size
 */

`timescale 1ns/1ps
`default_nettype none

module imem_sram #(
    parameter int IMEM_WORDS_X = 6
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    ibus_if.slave                       bus,
    input  logic                        load_we_i,
    input  logic [IMEM_WORDS_X-1:0]     load_addr_i,
    input  logic [pfu_pkg::xlen-1:0]    load_data_i
);
    import pfu_pkg::*;

    // word array
    logic [xlen-1:0]         mem_q [2**IMEM_WORDS_X];
    logic                    req_take;
    logic                    in_range;
    logic [IMEM_WORDS_X-1:0] word_idx;

    // a held response blocks new requests
    assign bus.req_ready = ~bus.rsp_valid | bus.rsp_ready;
    assign req_take      = bus.req_valid & bus.req_ready;

    assign word_idx = bus.req_addr[IMEM_WORDS_X+1:2];
    // any address bit above the array means out of range
    assign in_range = ~(|bus.req_addr[xlen-1:IMEM_WORDS_X+2]);

    // load port
    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bus.rsp_valid <= 1'b0;
            bus.rsp_rerr  <= 1'b0;
        end else begin
            bus.rsp_valid <= req_take | (bus.rsp_valid & ~bus.rsp_ready);
            if (req_take) begin
                bus.rsp_rerr <= ~in_range;
            end
        end
    end

    // read data is zero for an error
    always_ff @(posedge clk_i) begin
        if (req_take) begin
            bus.rsp_data <= in_range ? mem_q[word_idx] : '0;
        end
    end

endmodule

`default_nettype wire

//--- design/pfu_subsys.sv
/*
 * pre-fetch subsystem
 * pre-fetch unit paired with an on-chip instruction SRAM
 */

`timescale 1ns/1ps
`default_nettype none

module pfu_subsys #(
    parameter int                        FIFO_DEPTH_X     = 2,
    parameter bit                        FIFO_PASSTHROUGH = 1'b0,
    parameter logic [pfu_pkg::xlen-1:0]  RESET_VECTOR     = '0,
    parameter int                        IMEM_WORDS_X     = 6
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    // SRAM load port
    input  logic                         load_we_i,
    input  logic [IMEM_WORDS_X-1:0]      load_addr_i,
    input  logic [pfu_pkg::xlen-1:0]     load_data_i,
    // execute stage
    input  pfu_pkg::hpl_t                exs_hpl_i,
    input  logic                         exs_pc_wr_i,
    input  logic [pfu_pkg::xlen-1:0]     exs_pc_din_i,
    // decoder
    output logic                         ids_dav_o,
    input  logic                         ids_ack_i,
    input  logic [1:0]                   ids_ack_size_i,
    output pfu_pkg::sofid_e              ids_sofid_o,
    output logic [pfu_pkg::xlen-1:0]     ids_ins_o,
    output logic                         ids_ferr_o,
    output logic [pfu_pkg::xlen-1:0]     ids_pc_o
);

    // fetch to memory bus
    ibus_if ibus ();

    pfu_fetch #(
        .FIFO_DEPTH_X     (FIFO_DEPTH_X),
        .FIFO_PASSTHROUGH (FIFO_PASSTHROUGH),
        .RESET_VECTOR     (RESET_VECTOR)
    ) u_fetch (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .bus            (ibus.master),
        .exs_hpl_i      (exs_hpl_i),
        .exs_pc_wr_i    (exs_pc_wr_i),
        .exs_pc_din_i   (exs_pc_din_i),
        .ids_dav_o      (ids_dav_o),
        .ids_ack_i      (ids_ack_i),
        .ids_ack_size_i (ids_ack_size_i),
        .ids_sofid_o    (ids_sofid_o),
        .ids_ins_o      (ids_ins_o),
        .ids_ferr_o     (ids_ferr_o),
        .ids_pc_o       (ids_pc_o)
    );

    imem_sram #(
        .IMEM_WORDS_X (IMEM_WORDS_X)
    ) u_sram (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bus         (ibus.slave),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

`default_nettype wire

//--- verif/pfu_subsys_sva.sv
/*
 * pre-fetch protocol assertions
 * single outstanding bus request, stable decoder output, redirect gating
 */

`timescale 1ns/1ps
`default_nettype none

module pfu_subsys_sva (
    input logic        clk_i,
    input logic        reset_i,
    input logic        request_i,
    input logic        response_i,
    input logic        exs_pc_wr_i,
    input logic        ids_dav_i,
    input logic        ids_ack_i,
    input logic [31:0] ids_ins_i
);

    int   assert_fail_count = 0;
    // one request on the bus not yet answered
    logic outstanding_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
        end else if (request_i & ~response_i) begin
            outstanding_q <= 1'b1;
        end else if (response_i & ~request_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // bus and decoder rules
    // ------------------------------------------------------------------------
    // back-to-back only when the answer lands in the same cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        request_i && outstanding_q |-> response_i)
    else begin
        assert_fail_count++;
        $error("second request issued with one outstanding");
    end

    // held instruction must not move without an ack
    assert property (@(posedge clk_i) disable iff (reset_i)
        ids_dav_i && !ids_ack_i && !exs_pc_wr_i |=> $stable(ids_ins_i))
    else begin
        assert_fail_count++;
        $error("ids_ins_o changed while held");
    end

    // redirect cycle never takes a request
    assert property (@(posedge clk_i) disable iff (reset_i)
        exs_pc_wr_i |-> !request_i)
    else begin
        assert_fail_count++;
        $error("request taken in the redirect cycle");
    end

endmodule

bind pfu_fetch pfu_subsys_sva i_pfu_sva (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .request_i   (request),
    .response_i  (response),
    .exs_pc_wr_i (exs_pc_wr_i),
    .ids_dav_i   (ids_dav_o),
    .ids_ack_i   (ids_ack_i),
    .ids_ins_i   (ids_ins_o)
);

`default_nettype wire

//--- verif/tb_pfu_subsys.sv
/*
 * testbench for the pre-fetch subsystem
 * loads a random program, applies a table of redirects and ack sizes,
 * and checks every instruction against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_pfu_subsys;
    import pfu_pkg::*;

    localparam int imem_words_x = 6;
    localparam int imem_words   = 2 ** imem_words_x;
    localparam int num_rows     = 9;

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    // row 0 runs straight from reset and the others redirect first
    localparam bit row_redirect [num_rows] = '{0, 1, 1, 1, 1, 1, 1, 1, 1};
    localparam logic [31:0] row_pc [num_rows] = '{
        32'h0000_0000, 32'h0000_0040, 32'h0000_0022, 32'h0000_00f0, 32'h0000_0010,
        32'h0000_0086, 32'h0000_0030, 32'h0000_00a4, 32'h0000_0012
    };
    localparam int row_count [num_rows] = '{24, 30, 20, 16, 40, 24, 5, 3, 20};
    // bit k%8 set means a 32-bit ack for instruction k
    localparam logic [7:0] row_pattern [num_rows] = '{
        8'hff, 8'hb2, 8'h6d, 8'h5a, 8'hca, 8'ha5, 8'h00, 8'hff, 8'h96
    };
    // longest random stall before an ack
    localparam int row_hold [num_rows] = '{0, 0, 0, 0, 6, 3, 0, 0, 2};

    logic                        clk_i;
    logic                        reset_i;
    logic                        load_we_i;
    logic [imem_words_x-1:0]     load_addr_i;
    logic [xlen-1:0]             load_data_i;
    hpl_t                        exs_hpl_i;
    logic                        exs_pc_wr_i;
    logic [xlen-1:0]             exs_pc_din_i;
    logic                        ids_dav_o;
    logic                        ids_ack_i;
    logic [1:0]                  ids_ack_size_i;
    sofid_e                      ids_sofid_o;
    logic [xlen-1:0]             ids_ins_o;
    logic                        ids_ferr_o;
    logic [xlen-1:0]             ids_pc_o;

    // reference model state
    logic [xlen-1:0] ref_mem [imem_words];
    logic [xlen-1:0] model_pc;
    logic            expect_jump;
    integer          seed;
    int              error_count;
    int              check_count;
    int              cycle_count;
    int              cycle_limit;

    pfu_subsys #(
        .FIFO_DEPTH_X     (2),
        .FIFO_PASSTHROUGH (1'b0),
        .RESET_VECTOR     (32'h0000_0000),
        .IMEM_WORDS_X     (imem_words_x)
    ) i_dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .load_we_i      (load_we_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .exs_hpl_i      (exs_hpl_i),
        .exs_pc_wr_i    (exs_pc_wr_i),
        .exs_pc_din_i   (exs_pc_din_i),
        .ids_dav_o      (ids_dav_o),
        .ids_ack_i      (ids_ack_i),
        .ids_ack_size_i (ids_ack_size_i),
        .ids_sofid_o    (ids_sofid_o),
        .ids_ins_o      (ids_ins_o),
        .ids_ferr_o     (ids_ferr_o),
        .ids_pc_o       (ids_pc_o)
    );

    // 4 ns clock
    always #2 clk_i = ~clk_i;

    // run limit from the table length
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: decoder still waiting after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic int timeout_limit();
        int total;
        total = 0;
        for (int r = 0; r < num_rows; r++) begin
            total += row_count[r];
        end
        return 40 * total + 200;
    endfunction

    // halfword at a byte address or zero past the end of the SRAM
    function automatic logic [15:0] halfword_at(input logic [31:0] addr);
        logic [29:0] word;
        word = addr[31:2];
        if (word >= imem_words) begin
            return 16'h0000;
        end
        return addr[1] ? ref_mem[word[imem_words_x-1:0]][31:16]
                       : ref_mem[word[imem_words_x-1:0]][15:0];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic apply_reset();
        repeat (5) @(posedge clk_i);
        #1;
        // fifos empty while held in reset
        check_value(32'(ids_dav_o), 32'd0, "ids_dav_o during reset");
        reset_i = 1'b0;
    endtask

    // one word per cycle ahead of the first fetches
    task automatic load_program();
        for (int i = 0; i < imem_words; i++) begin
            @(posedge clk_i);
            #1;
            load_we_i   = 1'b1;
            load_addr_i = imem_words_x'(i);
            load_data_i = ref_mem[i];
        end
        @(posedge clk_i);
        #1;
        load_we_i = 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        exs_pc_wr_i  = 1'b1;
        exs_pc_din_i = pc;
        @(posedge clk_i);
        #1;
        exs_pc_wr_i = 1'b0;
        model_pc    = pc;
        expect_jump = 1'b1;
    endtask

    // stall and wait for an instruction before checking and acking it
    task automatic consume_one(input int size, input int hold);
        logic [31:0] exp_ins;
        logic        exp_ferr;
        string       where;
        repeat (hold) begin
            @(posedge clk_i);
            #1;
        end
        while (!ids_dav_o) begin
            @(posedge clk_i);
            #1;
        end
        exp_ins  = {halfword_at(model_pc + 32'd2), halfword_at(model_pc)};
        exp_ferr = (model_pc[31:2] >= imem_words);
        where    = $sformatf("at pc %h", model_pc);
        check_value(ids_ins_o, exp_ins, {"ids_ins_o ", where});
        check_value(ids_pc_o, model_pc, {"ids_pc_o ", where});
        check_value(32'(ids_ferr_o), 32'(exp_ferr), {"ids_ferr_o ", where});
        check_value(32'(ids_sofid_o), 32'(expect_jump ? sofid_jump : sofid_run),
                    {"ids_sofid_o ", where});
        ids_ack_i      = 1'b1;
        ids_ack_size_i = 2'(size);
        @(posedge clk_i);
        #1;
        ids_ack_i   = 1'b0;
        model_pc    = model_pc + 32'(2 * size);
        expect_jump = 1'b0;
    endtask

    task automatic run_row(input int r);
        int size;
        int hold;
        if (row_redirect[r]) begin
            redirect_to(row_pc[r]);
        end else begin
            model_pc    = row_pc[r];
            expect_jump = 1'b0;
        end
        for (int k = 0; k < row_count[r]; k++) begin
            size = row_pattern[r][k % 8] ? 2 : 1;
            hold = $unsigned($random(seed)) % (row_hold[r] + 1);
            consume_one(size, hold);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        load_we_i      = 1'b0;
        load_addr_i    = '0;
        load_data_i    = '0;
        exs_hpl_i      = 2'b11;
        exs_pc_wr_i    = 1'b0;
        exs_pc_din_i   = '0;
        ids_ack_i      = 1'b0;
        ids_ack_size_i = 2'd2;
        error_count    = 0;
        check_count    = 0;
        cycle_count    = 0;
        cycle_limit    = timeout_limit();
        seed           = 39;
        for (int i = 0; i < imem_words; i++) begin
            ref_mem[i] = $random(seed);
        end
        fork
            apply_reset();
            load_program();
        join
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (4) @(posedge clk_i);
        error_count += i_dut.u_fetch.i_pfu_sva.assert_fail_count;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/pfu_pkg.sv
design/ibus_if.sv
design/pfu_fifo.sv
design/pfu_fetch.sv
design/imem_sram.sv
design/pfu_subsys.sv
verif/pfu_subsys_sva.sv
verif/tb_pfu_subsys.sv

//--- Bender.yml
package:
  name: pfu_subsys

sources:
  # shared package first, then interface and design in compile order
  - design/pfu_pkg.sv
  - design/ibus_if.sv
  - design/pfu_fifo.sv
  - design/pfu_fetch.sv
  - design/imem_sram.sv
  - design/pfu_subsys.sv
  - target: test
    files:
      - verif/pfu_subsys_sva.sv
      - verif/tb_pfu_subsys.sv

# top modules: pfu_subsys (design), tb_pfu_subsys (simulation)
